/* hdl/lc3b_defines.svh */
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// Data path and instruction width
`define LC3B_WORD_W 16

// General purpose register file
`define LC3B_NUM_REGS 8
`define LC3B_REG_W 3

`endif

/* hdl/lc3b_types.sv */
`default_nettype none

`include "lc3b_defines.svh"

package lc3b_types;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [`LC3B_REG_W-1:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp; // n, z, p

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} alu_ops;

	typedef struct packed {
		alu_ops aluop;
		logic srcb_imm; // Use sext(imm5) as operand b
		logic load_regfile;
		logic load_cc;
		logic is_branch;
		lc3b_reg dest;
		lc3b_reg src_a; // Source indices kept for forwarding
		lc3b_reg src_b;
	} lc3b_control;

endpackage

`default_nettype wire

/* hdl/lc3b_pipe_if.sv */
`default_nettype none

// Decode to execute
interface id_ex_if;
	import lc3b_types::*;

	logic valid;
	lc3b_word pc;
	lc3b_control ctrl;
	lc3b_word instr;
	lc3b_word srca_val;
	lc3b_word srcb_val;

	modport stage_out (output valid, pc, ctrl, instr, srca_val, srcb_val);
	modport stage_in (input valid, pc, ctrl, instr, srca_val, srcb_val);

endinterface

// Execute to writeback, also the forwarding source
interface ex_wb_if;
	import lc3b_types::*;

	logic valid;
	logic load_regfile;
	lc3b_reg dest;
	lc3b_word data;

	modport stage_out (output valid, load_regfile, dest, data);
	modport stage_in (input valid, load_regfile, dest, data);

endinterface

`default_nettype wire

/* hdl/regfile.sv */
`default_nettype none

`include "lc3b_defines.svh"

module regfile (
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_types::lc3b_reg dest,
	input lc3b_types::lc3b_word in,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);
	import lc3b_types::*;

	lc3b_word data [`LC3B_NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++)
				data[i] <= '0;
		end else if (load) begin
			data[dest] <= in;
		end
	end

	// Write-through so a read in the write cycle sees the new value
	always_comb begin
		reg_a = (load && (src_a == dest)) ? in : data[src_a];
		reg_b = (load && (src_b == dest)) ? in : data[src_b];
	end

endmodule

`default_nettype wire

/* hdl/decode.sv */
`default_nettype none

module decode (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input lc3b_types::lc3b_word instr,
	input lc3b_types::lc3b_word pc,
	ex_wb_if.stage_in wb,
	id_ex_if.stage_out id_ex
);
	import lc3b_types::*;

	logic ifid_valid;
	lc3b_word ifid_instr;
	lc3b_word ifid_pc;
	lc3b_opcode opcode;
	lc3b_control ctrl;
	lc3b_word reg_a;
	lc3b_word reg_b;

	// IF/ID
	always_ff @(posedge clk) begin
		if (reset)
			ifid_valid <= 1'b0;
		else
			ifid_valid <= instr_valid;
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			ifid_instr <= instr;
			ifid_pc <= pc;
		end
	end

	assign opcode = lc3b_opcode'(ifid_instr[15:12]);

	always_comb begin
		ctrl.aluop = alu_pass;
		ctrl.srcb_imm = 1'b0;
		ctrl.load_regfile = 1'b0;
		ctrl.load_cc = 1'b0;
		ctrl.is_branch = 1'b0;
		ctrl.dest = ifid_instr[11:9];
		ctrl.src_a = ifid_instr[8:6]; // SR1
		ctrl.src_b = ifid_instr[2:0]; // SR2

		if (ifid_valid) begin
			case (opcode)
				op_add: begin
					ctrl.aluop = alu_add;
					ctrl.srcb_imm = ifid_instr[5];
					ctrl.load_regfile = 1'b1;
					ctrl.load_cc = 1'b1;
				end
				op_and: begin
					ctrl.aluop = alu_and;
					ctrl.srcb_imm = ifid_instr[5];
					ctrl.load_regfile = 1'b1;
					ctrl.load_cc = 1'b1;
				end
				op_not: begin
					ctrl.aluop = alu_not;
					ctrl.load_regfile = 1'b1;
					ctrl.load_cc = 1'b1;
				end
				op_br: ctrl.is_branch = 1'b1;
				default: ; // Anything else goes down as a bubble
			endcase
		end
	end

	regfile u_regfile (
		.clk,
		.reset,
		.load(wb.valid & wb.load_regfile),
		.dest(wb.dest),
		.in(wb.data),
		.src_a(ctrl.src_a),
		.src_b(ctrl.src_b),
		.reg_a,
		.reg_b
	);

	// ID/EX
	always_ff @(posedge clk) begin
		if (reset) begin
			id_ex.valid <= 1'b0;
			id_ex.ctrl <= '0;
		end else begin
			id_ex.valid <= ifid_valid;
			id_ex.ctrl <= ctrl;
		end
	end

	always_ff @(posedge clk) begin
		id_ex.pc <= ifid_pc;
		id_ex.instr <= ifid_instr;
		id_ex.srca_val <= reg_a;
		id_ex.srcb_val <= reg_b;
	end

endmodule

`default_nettype wire

/* hdl/execute.sv */
`default_nettype none

module execute (
	input logic clk,
	input logic reset,
	id_ex_if.stage_in id_ex,
	ex_wb_if.stage_out ex_wb,
	output lc3b_types::lc3b_nzp cc,
	output logic branch_taken,
	output lc3b_types::lc3b_word branch_target
);
	import lc3b_types::*;

	lc3b_word src_a_fwd;
	lc3b_word src_b_fwd;
	lc3b_word imm5_sext;
	lc3b_word operand_b;
	lc3b_word alu_out;
	lc3b_word offset9;
	lc3b_word target;
	lc3b_nzp nzp_next;
	logic taken_next;

	// Result still sitting in EX/WB beats the value read in decode
	assign src_a_fwd = (ex_wb.load_regfile && (ex_wb.dest == id_ex.ctrl.src_a)) ?
		ex_wb.data : id_ex.srca_val;
	assign src_b_fwd = (ex_wb.load_regfile && (ex_wb.dest == id_ex.ctrl.src_b)) ?
		ex_wb.data : id_ex.srcb_val;

	assign imm5_sext = {{11{id_ex.instr[4]}}, id_ex.instr[4:0]};
	assign operand_b = id_ex.ctrl.srcb_imm ? imm5_sext : src_b_fwd;

	always_comb begin
		case (id_ex.ctrl.aluop)
			alu_add: alu_out = src_a_fwd + operand_b;
			alu_and: alu_out = src_a_fwd & operand_b;
			alu_not: alu_out = ~src_a_fwd;
			default: alu_out = src_a_fwd; // alu_pass
		endcase
	end

	always_comb begin
		if (alu_out[15])
			nzp_next = 3'b100;
		else if (alu_out == '0)
			nzp_next = 3'b010;
		else
			nzp_next = 3'b001;
	end

	// Branch target is PC of the next instruction plus offset9 << 1
	assign offset9 = {{6{id_ex.instr[8]}}, id_ex.instr[8:0], 1'b0};
	assign target = id_ex.pc + 16'd2 + offset9;
	assign taken_next = id_ex.valid && id_ex.ctrl.is_branch &&
		(|(id_ex.instr[11:9] & cc));

	// EX/WB
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_wb.valid <= 1'b0;
			ex_wb.load_regfile <= 1'b0;
			cc <= 3'b010; // Z out of reset
			branch_taken <= 1'b0;
		end else begin
			ex_wb.valid <= id_ex.valid;
			ex_wb.load_regfile <= id_ex.valid & id_ex.ctrl.load_regfile;
			if (id_ex.valid && id_ex.ctrl.load_cc)
				cc <= nzp_next;
			branch_taken <= taken_next;
		end
	end

	always_ff @(posedge clk) begin
		ex_wb.dest <= id_ex.ctrl.dest;
		ex_wb.data <= alu_out;
		branch_target <= target;
	end

endmodule

`default_nettype wire

/* hdl/lc3b_pipe.sv */
`default_nettype none

module lc3b_pipe (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input lc3b_types::lc3b_word instr,
	input lc3b_types::lc3b_word pc,
	output logic wb_valid,
	output logic wb_load,
	output lc3b_types::lc3b_reg wb_dest,
	output lc3b_types::lc3b_word wb_data,
	output lc3b_types::lc3b_nzp cc,
	output logic branch_taken,
	output lc3b_types::lc3b_word branch_target
);

	id_ex_if id_ex ();
	ex_wb_if ex_wb ();

	decode u_decode (
		.clk,
		.reset,
		.instr_valid,
		.instr,
		.pc,
		.wb(ex_wb.stage_in),
		.id_ex(id_ex.stage_out)
	);

	execute u_execute (
		.clk,
		.reset,
		.id_ex(id_ex.stage_in),
		.ex_wb(ex_wb.stage_out),
		.cc,
		.branch_taken,
		.branch_target
	);

	// Writeback bundle goes out as plain ports
	assign wb_valid = ex_wb.valid;
	assign wb_load = ex_wb.load_regfile;
	assign wb_dest = ex_wb.dest;
	assign wb_data = ex_wb.data;

endmodule

`default_nettype wire

/* dv/lc3b_pipe_asserts.sv */
`default_nettype none

module lc3b_pipe_asserts (
	input logic clk,
	input logic reset,
	input logic id_ex_valid,
	input logic id_ex_branch,
	input logic ex_wb_valid,
	input logic wb_valid,
	input logic branch_taken,
	input lc3b_types::lc3b_nzp cc
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0; // Read by the testbench at the end

	wb_idle_after_reset: assert property (@(posedge clk) reset |=> !wb_valid)
		else begin
			$error("wb_valid high in the cycle after reset");
			fail_count++;
		end

	// Every EX/WB item came out of ID/EX one cycle earlier
	wb_from_id_ex: assert property (@(posedge clk) disable iff (reset)
		ex_wb_valid |-> $past(id_ex_valid))
		else begin
			$error("EX/WB valid without an ID/EX item the cycle before");
			fail_count++;
		end

	taken_only_on_br: assert property (@(posedge clk) disable iff (reset)
		branch_taken |-> ex_wb_valid && $past(id_ex_valid && id_ex_branch))
		else begin
			$error("branch_taken without a BR in EX/WB");
			fail_count++;
		end

	cc_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(cc))
		else begin
			$error("cc is not one-hot");
			fail_count++;
		end

endmodule

bind lc3b_pipe lc3b_pipe_asserts u_asserts (
	.clk,
	.reset,
	.id_ex_valid(id_ex.valid),
	.id_ex_branch(id_ex.ctrl.is_branch),
	.ex_wb_valid(ex_wb.valid),
	.wb_valid,
	.branch_taken,
	.cc
);

`default_nettype wire

/* dv/tb_lc3b_pipe.sv */
`default_nettype none

`include "lc3b_defines.svh"

module tb_lc3b_pipe;
	timeunit 1ns;
	timeprecision 100ps;

	import lc3b_types::*;

	localparam int directed_len = 56;
	localparam int random_len = 300;
	localparam int watchdog_cycles = (directed_len + random_len) * 4 + 200;

	typedef struct packed {
		logic load;
		lc3b_reg dest;
		lc3b_word data;
		lc3b_nzp cc;
		logic is_br;
		logic taken;
		lc3b_word target;
		int due_cycle; // Cycle in which wb_valid has to show up
	} expect_t;

	logic clk;
	logic reset;
	logic instr_valid;
	lc3b_word instr;
	lc3b_word pc;
	logic wb_valid;
	logic wb_load;
	lc3b_reg wb_dest;
	lc3b_word wb_data;
	lc3b_nzp cc;
	logic branch_taken;
	lc3b_word branch_target;

	lc3b_word model_regs [`LC3B_NUM_REGS];
	lc3b_nzp model_cc;
	expect_t exp_q [$];
	lc3b_word next_pc = 16'h3000;
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	int err_mark = 0;

	lc3b_pipe u_lc3b_pipe (
		.clk,
		.reset,
		.instr_valid,
		.instr,
		.pc,
		.wb_valid,
		.wb_load,
		.wb_dest,
		.wb_data,
		.cc,
		.branch_taken,
		.branch_target
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic lc3b_nzp sign_of(lc3b_word v);
		if (v[15])
			return 3'b100;
		else if (v == 16'h0000)
			return 3'b010;
		return 3'b001;
	endfunction

	// ISA model, called once per accepted instruction in program order
	function automatic expect_t model_step(lc3b_word ins, lc3b_word ins_pc);
		expect_t e;
		lc3b_word a;
		lc3b_word b;
		lc3b_word r;
		e = '0;
		a = model_regs[ins[8:6]];
		b = ins[5] ? {{11{ins[4]}}, ins[4:0]} : model_regs[ins[2:0]];
		case (lc3b_opcode'(ins[15:12]))
			op_add: r = a + b;
			op_and: r = a & b;
			op_not: r = ~a;
			default: r = '0;
		endcase
		e.load = ins[15:12] inside {op_add, op_and, op_not};
		e.is_br = (ins[15:12] == op_br);
		e.taken = e.is_br && (|(ins[11:9] & model_cc));
		e.target = ins_pc + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
		e.dest = ins[11:9];
		if (e.load) begin
			model_regs[ins[11:9]] = r;
			model_cc = sign_of(r);
			e.data = r;
		end
		e.cc = model_cc;
		return e;
	endfunction

	function automatic lc3b_word alu_instr(lc3b_opcode op, lc3b_reg d, lc3b_reg s1, logic imm,
		logic [4:0] low);
		return {op, d, s1, imm, low};
	endfunction

	task automatic check_word(string name, lc3b_word got, lc3b_word exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_reg(string name, lc3b_reg got, lc3b_reg exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_nzp(string name, lc3b_nzp got, lc3b_nzp exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
		end
	endtask

	// Compare every writeback against the oldest model record
	always @(negedge clk) begin : compare
		expect_t e;
		if (!reset && wb_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Unexpected writeback at %0t with nothing outstanding", $time);
			end else begin
				e = exp_q.pop_front();
				if (cycle != e.due_cycle) begin
					errors++;
					$display("Writeback at %0t came in cycle %0d instead of cycle %0d",
						$time, cycle, e.due_cycle);
				end
				check_bit("wb_load", wb_load, e.load);
				check_bit("branch_taken", branch_taken, e.taken);
				check_nzp("cc", cc, e.cc);
				if (e.load) begin
					check_reg("wb_dest", wb_dest, e.dest);
					check_word("wb_data", wb_data, e.data);
				end
				if (e.is_br)
					check_word("branch_target", branch_target, e.target);
			end
		end
	end

	task automatic send(lc3b_word ins, int gap);
		expect_t e;
		@(negedge clk);
		instr_valid = 1'b1;
		instr = ins;
		pc = next_pc;
		e = model_step(ins, next_pc);
		e.due_cycle = cycle + 3;
		exp_q.push_back(e);
		next_pc = next_pc + 16'd2;
		repeat (gap) begin
			@(negedge clk);
			instr_valid = 1'b0;
		end
	endtask

	task automatic finish_test(string name);
		@(negedge clk);
		instr_valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk); // Catch stray writebacks
		$display("Test %s finished with %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	task automatic alu_tests();
		send(alu_instr(op_add, 3'd1, 3'd0, 1'b1, 5'd5), 2);
		send(alu_instr(op_add, 3'd2, 3'd0, 1'b1, 5'h1d), 2); // -3
		send(alu_instr(op_add, 3'd3, 3'd1, 1'b0, 5'd2), 2);
		send(alu_instr(op_and, 3'd4, 3'd1, 1'b0, 5'd2), 2);
		send(alu_instr(op_not, 3'd5, 3'd1, 1'b1, 5'h1f), 2);
		send(alu_instr(op_and, 3'd6, 3'd5, 1'b0, 5'd1), 2);
		finish_test("register forms");
		send(alu_instr(op_add, 3'd1, 3'd1, 1'b1, 5'h10), 2); // -16
		send(alu_instr(op_add, 3'd2, 3'd2, 1'b1, 5'd15), 2);
		send(alu_instr(op_and, 3'd3, 3'd2, 1'b1, 5'h1f), 2);
		send(alu_instr(op_and, 3'd4, 3'd1, 1'b1, 5'd10), 2);
		send(alu_instr(op_add, 3'd7, 3'd0, 1'b1, 5'h1f), 2);
		finish_test("immediate forms");
	endtask

	task automatic hazard_test();
		send(alu_instr(op_add, 3'd1, 3'd0, 1'b1, 5'd7), 0);
		send(alu_instr(op_add, 3'd1, 3'd1, 1'b1, 5'h1e), 0);
		send(alu_instr(op_add, 3'd2, 3'd1, 1'b0, 5'd1), 0);
		send(alu_instr(op_and, 3'd3, 3'd2, 1'b0, 5'd1), 0);
		send(alu_instr(op_not, 3'd4, 3'd3, 1'b1, 5'h1f), 0);
		send(alu_instr(op_add, 3'd5, 3'd4, 1'b0, 5'd2), 0);
		// Distance 2 through the register file bypass
		send(alu_instr(op_add, 3'd6, 3'd5, 1'b1, 5'd3), 1);
		send(alu_instr(op_add, 3'd6, 3'd6, 1'b0, 5'd5), 1);
		send(alu_instr(op_not, 3'd7, 3'd6, 1'b1, 5'h1f), 1);
		send(alu_instr(op_add, 3'd1, 3'd0, 1'b1, 5'd1), 0);
		send(alu_instr(op_add, 3'd2, 3'd0, 1'b1, 5'd2), 0);
		send(alu_instr(op_add, 3'd3, 3'd1, 1'b0, 5'd2), 0);
		finish_test("forwarding and bypass");
	endtask

	task automatic branch_test();
		lc3b_word ins;
		for (int s = 0; s < 3; s++) begin
			send(alu_instr(op_add, 3'd1, 3'd0, 1'b1,
				(s == 0) ? 5'h1c : (s == 1) ? 5'h00 : 5'h03), 0);
			for (int m = 0; m < 8; m++)
				send({op_br, 3'(m), 9'($urandom)}, 0);
		end
		for (int k = 0; k < 6; k++) begin
			ins = 16'($urandom);
			ins[15:12] = (k < 3) ? ((k == 0) ? op_ldr : (k == 1) ? op_str : op_trap)
				: ((k == 3) ? op_jmp : (k == 4) ? op_lea : op_shf);
			send(ins, 0);
		end
		finish_test("branches and bubbles");
	endtask

	task automatic random_test();
		lc3b_word ins;
		for (int i = 0; i < random_len; i++) begin
			ins = 16'($urandom);
			case ($urandom % 4)
				0: ins[15:12] = op_add;
				1: ins[15:12] = op_and;
				2: ins[15:12] = op_not;
				default: ins[15:12] = op_br;
			endcase
			send(ins, ($urandom % 4 == 0) ? 1 : 0);
		end
		finish_test("random stream");
	endtask

	initial begin
		void'($urandom(44));
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		model_cc = 3'b010;
		for (int i = 0; i < `LC3B_NUM_REGS; i++)
			model_regs[i] = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		repeat (5) begin
			@(negedge clk);
			check_bit("wb_valid", wb_valid, 1'b0);
			check_nzp("cc", cc, 3'b010);
		end
		finish_test("reset state");
		alu_tests();
		hazard_test();
		branch_test();
		random_test();
		errors += u_lc3b_pipe.u_asserts.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, the tests did not complete", watchdog_cycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/lc3b_types.sv
hdl/lc3b_pipe_if.sv
hdl/regfile.sv
hdl/decode.sv
hdl/execute.sv
hdl/lc3b_pipe.sv
dv/lc3b_pipe_asserts.sv
dv/tb_lc3b_pipe.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_lc3b_pipe
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
